// ==== source/fpu_ncp_pkg.sv ====
/*
 * Shared definitions for the non-computational FPU path.
 * Holds the widths, pipe latencies, operation codes and the request and
 * response records. Modules take it by a wildcard import in their header.
 */
`default_nettype none

package fpu_ncp_pkg;

    ////////////////////////////////////////////////////////////
    // widths and latencies
    ////////////////////////////////////////////////////////////

    localparam int FLEN      = 32;
    localparam int NUM_LANES = 2;
    localparam int TAG_W     = 4;
    localparam int LAT_SIGN  = 1;
    localparam int LAT_CMP   = 2;

    localparam logic [FLEN-1:0] QNAN_CANON = 32'h7fc00000;

    typedef logic [FLEN-1:0]      lane_data_t;
    typedef lane_data_t [NUM_LANES-1:0] lane_vec_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [TAG_W-1:0]     tag_t;

    ////////////////////////////////////////////////////////////
    // operations and records
    ////////////////////////////////////////////////////////////

    // codes above OP_FCLASS are not defined and act as a plain sign injection
    typedef enum logic [3:0] {
        OP_SGNJ   = 4'd0,
        OP_SGNJN  = 4'd1,
        OP_SGNJX  = 4'd2,
        OP_FEQ    = 4'd3,
        OP_FLT    = 4'd4,
        OP_FLE    = 4'd5,
        OP_FMIN   = 4'd6,
        OP_FMAX   = 4'd7,
        OP_FCLASS = 4'd8
    } fpu_op_t;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        tag_t       tag;
        fpu_op_t    op;
        lane_mask_t lane_mask;
        lane_vec_t  a;
        lane_vec_t  b;
    } fpu_req_t;

    typedef struct packed {
        tag_t      tag;
        lane_vec_t result;
        logic      has_fflags;
        fflags_t   fflags;
    } fpu_rsp_t;

endpackage

`default_nettype wire

// ==== source/fpu_dispatch.sv ====
/*
 * Request steering for the non-computational FPU path.
 * Decodes the operation into a function unit, raises the valid of that
 * unit only and hands its ready back to the requester.
 */
`timescale 1ns/100ps
`default_nettype none

module fpu_dispatch import fpu_ncp_pkg::*; (
    input  logic    valid_in,
    input  fpu_op_t op,
    input  logic    sign_ready,
    input  logic    cmp_ready,
    output logic    sign_valid,
    output logic    cmp_valid,
    output logic    ready_in
);

    logic is_cmp;

    // compares, min/max and classify go to the compare unit
    always_comb begin
        case (op)
            OP_FEQ,
            OP_FLT,
            OP_FLE,
            OP_FMIN,
            OP_FMAX,
            OP_FCLASS: is_cmp = 1'b1;
            default:   is_cmp = 1'b0;
        endcase
    end

    assign sign_valid = valid_in && !is_cmp;
    assign cmp_valid  = valid_in && is_cmp;

    // the requester only sees the ready of the unit it is aimed at
    assign ready_in = is_cmp ? cmp_ready : sign_ready;

endmodule

`default_nettype wire

// ==== source/fpu_pipe_reg.sv ====
/*
 * Stallable delay line of response records, DEPTH stages deep.
 * Each stage has a valid bit that is cleared by reset. All stages move
 * together while enable is high and hold otherwise.
 */
`timescale 1ns/100ps
`default_nettype none

module fpu_pipe_reg import fpu_ncp_pkg::*; #(
    parameter int DEPTH = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     in_valid,
    input  fpu_rsp_t in_rsp,
    output logic     out_valid,
    output fpu_rsp_t out_rsp
);

    logic [DEPTH-1:0] valid_q;
    fpu_rsp_t         rsp_q [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q[0] <= in_valid;
            for (int i = DEPTH - 1; i > 0; i--) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            rsp_q[0] <= in_rsp;
            for (int i = DEPTH - 1; i > 0; i--) begin
                rsp_q[i] <= rsp_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_rsp   = rsp_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== source/fpu_sign_unit.sv ====
/*
 * Sign-injection unit, one lane per operand word.
 * Builds the magnitude of a with a sign taken from b, its inverse or the
 * XOR of both signs, and delays the result LAT_SIGN cycles.
 */
`timescale 1ns/100ps
`default_nettype none

module fpu_sign_unit import fpu_ncp_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  fpu_req_t req,
    input  logic     out_ready,
    output logic     ready,
    output logic     out_valid,
    output fpu_rsp_t out_rsp
);

    logic [NUM_LANES-1:0] sign_bit;
    lane_vec_t            lane_res;
    fpu_rsp_t             unit_rsp;

    // pick the new sign per lane, unknown codes fall back to plain SGNJ
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            case (req.op)
                OP_SGNJN: sign_bit[i] = !req.b[i][FLEN-1];
                OP_SGNJX: sign_bit[i] = req.a[i][FLEN-1] ^ req.b[i][FLEN-1];
                default:  sign_bit[i] = req.b[i][FLEN-1];
            endcase
            lane_res[i] = {sign_bit[i], req.a[i][FLEN-2:0]};
        end
    end

    // sign injection never raises an exception
    always_comb begin
        unit_rsp            = '0;
        unit_rsp.tag        = req.tag;
        unit_rsp.result     = lane_res;
        unit_rsp.has_fflags = 1'b0;
    end

    // the pipe only holds when its last stage is full and not taken
    assign ready = out_ready || !out_valid;

    fpu_pipe_reg #(
        .DEPTH (LAT_SIGN)
    ) sign_pipe (
        .clk       (clk),
        .reset     (reset),
        .enable    (ready),
        .in_valid  (in_valid),
        .in_rsp    (unit_rsp),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

endmodule

`default_nettype wire

// ==== source/fpu_cmp_unit.sv ====
/*
 * Compare unit for equal, less-than, less-or-equal, min, max and classify.
 * Each lane is evaluated on its own, the invalid flags of the active lanes
 * are merged, and the record is delayed LAT_CMP cycles.
 */
`timescale 1ns/100ps
`default_nettype none

module fpu_cmp_unit import fpu_ncp_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  fpu_req_t req,
    input  logic     out_ready,
    output logic     ready,
    output logic     out_valid,
    output fpu_rsp_t out_rsp
);

    ////////////////////////////////////////////////////////////
    // single lane evaluation
    ////////////////////////////////////////////////////////////

    function automatic lane_data_t cmp_lane(
        input  fpu_op_t    op,
        input  lane_data_t a,
        input  lane_data_t b,
        output logic       nv
    );
        logic       a_nan, b_nan, a_snan, b_snan, any_nan;
        logic       a_zero, b_zero, a_inf, a_sub, a_norm;
        logic       eq, lt, lt_tot;
        logic [9:0] cls;
        lane_data_t res;

        a_nan   = (a[30:23] == 8'hff) && (a[22:0] != '0);
        b_nan   = (b[30:23] == 8'hff) && (b[22:0] != '0);
        a_snan  = a_nan && !a[22];
        b_snan  = b_nan && !b[22];
        any_nan = a_nan || b_nan;
        a_zero  = (a[30:0] == '0);
        b_zero  = (b[30:0] == '0);
        a_inf   = (a[30:23] == 8'hff) && (a[22:0] == '0);
        a_sub   = (a[30:23] == 8'h00) && (a[22:0] != '0);
        a_norm  = (a[30:23] != 8'h00) && (a[30:23] != 8'hff);

        // total order with -0 below +0, used by min and max
        if (a[31] != b[31]) begin
            lt_tot = a[31];
        end else if (a[31]) begin
            lt_tot = a[30:0] > b[30:0];
        end else begin
            lt_tot = a[30:0] < b[30:0];
        end

        // the IEEE relations treat both zeros as equal
        eq = (a == b) || (a_zero && b_zero);
        lt = lt_tot && !(a_zero && b_zero);

        cls = {a_nan && a[22], a_snan,
               !a[31] && a_inf, !a[31] && a_norm, !a[31] && a_sub, !a[31] && a_zero,
               a[31] && a_zero, a[31] && a_sub, a[31] && a_norm, a[31] && a_inf};

        res = '0;
        nv  = 1'b0;
        case (op)
            OP_FEQ: begin
                res[0] = !any_nan && eq;
                nv     = a_snan || b_snan;
            end
            OP_FLT: begin
                res[0] = !any_nan && lt;
                nv     = any_nan;
            end
            OP_FLE: begin
                res[0] = !any_nan && (lt || eq);
                nv     = any_nan;
            end
            OP_FMIN, OP_FMAX: begin
                if (a_nan && b_nan) begin
                    res = QNAN_CANON;
                end else if (a_nan) begin
                    res = b;
                end else if (b_nan) begin
                    res = a;
                end else if (op == OP_FMIN) begin
                    res = lt_tot ? a : b;
                end else begin
                    res = lt_tot ? b : a;
                end
                nv = a_snan || b_snan;
            end
            OP_FCLASS: res[9:0] = cls;
            default:   res = '0;
        endcase
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // lanes, flag merge and pipe
    ////////////////////////////////////////////////////////////

    lane_vec_t            lane_res;
    logic [NUM_LANES-1:0] lane_nv;
    fflags_t              merged_flags;
    fpu_rsp_t             unit_rsp;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_res[i] = cmp_lane(req.op, req.a[i], req.b[i], lane_nv[i]);
        end
    end

    // inactive lanes must not leak an invalid flag
    always_comb begin
        merged_flags = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (req.lane_mask[i]) begin
                merged_flags.nv = merged_flags.nv | lane_nv[i];
            end
        end
    end

    always_comb begin
        unit_rsp.tag        = req.tag;
        unit_rsp.result     = lane_res;
        unit_rsp.has_fflags = (req.op != OP_FCLASS);
        unit_rsp.fflags     = merged_flags;
    end

    assign ready = out_ready || !out_valid;

    fpu_pipe_reg #(
        .DEPTH (LAT_CMP)
    ) cmp_pipe (
        .clk       (clk),
        .reset     (reset),
        .enable    (ready),
        .in_valid  (in_valid),
        .in_rsp    (unit_rsp),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

endmodule

`default_nettype wire

// ==== source/fpu_rsp_arb.sv ====
/*
 * Round-robin merge of the sign unit (input a) and compare unit (input b)
 * onto one response stream. The output is combinational from the granted
 * input, and the grant stays put while the output is held.
 */
`timescale 1ns/100ps
`default_nettype none

module fpu_rsp_arb import fpu_ncp_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_a,
    input  logic     valid_b,
    input  fpu_rsp_t rsp_a,
    input  fpu_rsp_t rsp_b,
    output logic     ready_a,
    output logic     ready_b,
    output logic     valid_out,
    output fpu_rsp_t rsp,
    input  logic     ready_out
);

    // round-robin pointer, high when input b has priority
    logic prefer_b;
    logic grant_b;

    // the favoured input wins if it is valid, otherwise the other one
    assign grant_b = valid_b && (prefer_b || !valid_a);

    assign valid_out = valid_a || valid_b;
    assign rsp       = grant_b ? rsp_b : rsp_a;
    assign ready_a   = ready_out && !grant_b;
    assign ready_b   = ready_out && grant_b;

    // a held output pins the pointer to the current grant, so a late
    // arrival on the other input cannot change rsp before it is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            prefer_b <= 1'b0;
        end else if (valid_out) begin
            if (ready_out) begin
                prefer_b <= !grant_b;
            end else begin
                prefer_b <= grant_b;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fpu_ncp.sv ====
/*
 * Top of the non-computational FPU path.
 * A request is steered to the sign or the compare unit, and the two
 * result streams are merged back by a round-robin arbiter.
 */
`timescale 1ns/100ps
`default_nettype none

module fpu_ncp import fpu_ncp_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    input  fpu_req_t req,
    output logic     ready_in,
    output logic     valid_out,
    output fpu_rsp_t rsp,
    input  logic     ready_out
);

    logic     sign_valid, sign_ready;
    logic     cmp_valid, cmp_ready;
    logic     sign_out_valid, sign_out_ready;
    logic     cmp_out_valid, cmp_out_ready;
    fpu_rsp_t sign_rsp, cmp_rsp;

    fpu_dispatch dispatch (
        .valid_in   (valid_in),
        .op         (req.op),
        .sign_ready (sign_ready),
        .cmp_ready  (cmp_ready),
        .sign_valid (sign_valid),
        .cmp_valid  (cmp_valid),
        .ready_in   (ready_in)
    );

    fpu_sign_unit sign_unit (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sign_valid),
        .req       (req),
        .out_ready (sign_out_ready),
        .ready     (sign_ready),
        .out_valid (sign_out_valid),
        .out_rsp   (sign_rsp)
    );

    fpu_cmp_unit cmp_unit (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cmp_valid),
        .req       (req),
        .out_ready (cmp_out_ready),
        .ready     (cmp_ready),
        .out_valid (cmp_out_valid),
        .out_rsp   (cmp_rsp)
    );

    fpu_rsp_arb rsp_arb (
        .clk       (clk),
        .reset     (reset),
        .valid_a   (sign_out_valid),
        .valid_b   (cmp_out_valid),
        .rsp_a     (sign_rsp),
        .rsp_b     (cmp_rsp),
        .ready_a   (sign_out_ready),
        .ready_b   (cmp_out_ready),
        .valid_out (valid_out),
        .rsp       (rsp),
        .ready_out (ready_out)
    );

endmodule

`default_nettype wire

// ==== sim/tb_fpu_ncp.sv ====
/*
 * Directed testbench for the non-computational FPU path.
 * Each request is scored against a reference model by tag in a response
 * monitor. One line is printed per test, then a summary of the counts.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_fpu_ncp import fpu_ncp_pkg::*; ();

    localparam int TIMEOUT = 400;

    logic     clk, reset, valid_in, ready_in, valid_out, ready_out;
    fpu_req_t req;
    fpu_rsp_t rsp;

    int       errors, issued_count, rx_count, next_tag, test_count;
    fpu_rsp_t exp_rsp [1<<TAG_W];
    logic     pending [1<<TAG_W];
    logic     exp_is_cmp [1<<TAG_W];
    tag_t     sign_order [$];
    tag_t     cmp_order [$];
    logic     held, issue_done;
    fpu_rsp_t held_rsp, last_rsp;

    fpu_ncp fpu_ncp_inst (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .req       (req),
        .ready_in  (ready_in),
        .valid_out (valid_out),
        .rsp       (rsp),
        .ready_out (ready_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic is_nan(input lane_data_t x);
        return (x[30:23] == 8'hff) && (x[22:0] != 0);
    endfunction

    function automatic logic is_snan(input lane_data_t x);
        return is_nan(x) && !x[22];
    endfunction

    function automatic logic goes_to_cmp(input logic [3:0] code);
        return (code >= 4'd3) && (code <= 4'd8);
    endfunction

    // signed magnitude as an integer, both zeros map to 0
    function automatic longint order_key(input lane_data_t x);
        longint mag;
        mag = x[30:0];
        return x[31] ? -mag : mag;
    endfunction

    function automatic lane_data_t min_max(input lane_data_t a, input lane_data_t b,
                                           input logic want_max);
        logic a_smaller;
        if (is_nan(a) && is_nan(b)) return QNAN_CANON;
        if (is_nan(a)) return b;
        if (is_nan(b)) return a;
        if (order_key(a) == order_key(b)) begin
            a_smaller = a[31];
        end else begin
            a_smaller = order_key(a) < order_key(b);
        end
        return (a_smaller ^ want_max) ? a : b;
    endfunction

    function automatic logic [9:0] class_mask(input lane_data_t x);
        int idx;
        if (is_nan(x)) idx = x[22] ? 9 : 8;
        else if (x[30:23] == 8'hff) idx = x[31] ? 0 : 7;
        else if (x[30:23] != 8'h00) idx = x[31] ? 1 : 6;
        else if (x[22:0] != 0) idx = x[31] ? 2 : 5;
        else idx = x[31] ? 3 : 4;
        return 10'b1 << idx;
    endfunction

    function automatic fpu_rsp_t model(input fpu_req_t r);
        fpu_rsp_t   m;
        lane_data_t a, b;
        logic       nv, unord;
        m     = '0;
        m.tag = r.tag;
        for (int i = 0; i < NUM_LANES; i++) begin
            a     = r.a[i];
            b     = r.b[i];
            unord = is_nan(a) || is_nan(b);
            nv    = 1'b0;
            case (r.op)
                OP_FEQ: begin
                    m.result[i] = !unord && (order_key(a) == order_key(b));
                    nv = is_snan(a) || is_snan(b);
                end
                OP_FLT: begin
                    m.result[i] = !unord && (order_key(a) < order_key(b));
                    nv = unord;
                end
                OP_FLE: begin
                    m.result[i] = !unord && (order_key(a) <= order_key(b));
                    nv = unord;
                end
                OP_FMIN, OP_FMAX: begin
                    m.result[i] = min_max(a, b, r.op == OP_FMAX);
                    nv = is_snan(a) || is_snan(b);
                end
                OP_FCLASS: m.result[i] = class_mask(a);
                OP_SGNJN:  m.result[i] = {~b[31], a[30:0]};
                OP_SGNJX:  m.result[i] = {a[31] ^ b[31], a[30:0]};
                default:   m.result[i] = {b[31], a[30:0]};
            endcase
            if (r.lane_mask[i]) m.fflags.nv = m.fflags.nv | nv;
        end
        m.has_fflags = goes_to_cmp(r.op) && (r.op != OP_FCLASS);
        return m;
    endfunction

    // class representatives plus 2.0 and a negative signaling NaN
    function automatic lane_data_t special_value(input int idx);
        case (idx)
            0:       return 32'hff800000;
            1:       return 32'hbf800000;
            2:       return 32'h80000001;
            3:       return 32'h80000000;
            4:       return 32'h00000000;
            5:       return 32'h00000001;
            6:       return 32'h3f800000;
            7:       return 32'h7f800000;
            8:       return 32'h7f800001;
            9:       return 32'h7fc00000;
            10:      return 32'h40000000;
            default: return 32'hffa00000;
        endcase
    endfunction

    function automatic lane_data_t random_operand();
        if ($urandom % 4 == 0) return special_value($urandom % 12);
        return $urandom;
    endfunction

    ////////////////////////////////////////////////////////////
    // reporting, driving and response monitor
    ////////////////////////////////////////////////////////////

    task automatic report_value(input string name, input logic [79:0] got,
                                input logic [79:0] exp);
        errors++;
        $display("ERROR t=%0t %s: got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("FAIL t=%0t %s", $time, msg);
    endtask

    task automatic abort_run(input string msg);
        $display("timeout at t=%0t: %s", $time, msg);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic take_rsp(input fpu_rsp_t got);
        tag_t t;
        tag_t head;
        t        = got.tag;
        last_rsp = got;
        rx_count++;
        if (pending[t] !== 1'b1) begin
            report_fail($sformatf("response with tag %0d was not outstanding", t));
        end else begin
            pending[t] = 1'b0;
            if (got.result !== exp_rsp[t].result) begin
                report_value("rsp.result", got.result, exp_rsp[t].result);
            end
            if (got.has_fflags !== exp_rsp[t].has_fflags) begin
                report_value("rsp.has_fflags", got.has_fflags, exp_rsp[t].has_fflags);
            end
            if (got.fflags !== exp_rsp[t].fflags) begin
                report_value("rsp.fflags", got.fflags, exp_rsp[t].fflags);
            end
            head = exp_is_cmp[t] ? cmp_order.pop_front() : sign_order.pop_front();
            if (head !== t) report_value("rsp.tag (unit order)", t, head);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            held = 1'b0;
        end else if (valid_out === 1'b1) begin
            if (held && rsp !== held_rsp) report_value("rsp (held)", rsp, held_rsp);
            if (ready_out === 1'b1) begin
                take_rsp(rsp);
                held = 1'b0;
            end else begin
                held     = 1'b1;
                held_rsp = rsp;
            end
        end else if (held) begin
            report_fail("valid_out dropped before its response was taken");
            held = 1'b0;
        end
    end

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic issue_req(input fpu_req_t r);
        int   waited;
        logic accepted;
        exp_rsp[r.tag]    = model(r);
        pending[r.tag]    = 1'b1;
        exp_is_cmp[r.tag] = goes_to_cmp(r.op);
        if (goes_to_cmp(r.op)) cmp_order.push_back(r.tag);
        else sign_order.push_back(r.tag);
        issued_count++;
        valid_in = 1'b1;
        req      = r;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = (ready_in === 1'b1);
            if (!accepted) begin
                waited++;
                if (waited > TIMEOUT) abort_run("request was never accepted");
                @(negedge clk);
            end
        end
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    task automatic send(input logic [3:0] code, input lane_data_t a0, input lane_data_t b0,
                        input lane_data_t a1, input lane_data_t b1, input lane_mask_t mask);
        fpu_req_t r;
        r.tag       = tag_t'(next_tag);
        r.op        = fpu_op_t'(code);
        r.lane_mask = mask;
        r.a[0]      = a0;
        r.b[0]      = b0;
        r.a[1]      = a1;
        r.b[1]      = b1;
        next_tag++;
        issue_req(r);
    endtask

    task automatic wait_all_done(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (rx_count < issued_count) begin
            waited++;
            if (waited > TIMEOUT) abort_run({"missing responses in ", what});
            @(negedge clk);
        end
    endtask

    task automatic run_one(input logic [3:0] code, input lane_data_t a0, input lane_data_t b0,
                           input lane_data_t a1, input lane_data_t b1, input lane_mask_t mask);
        send(code, a0, b0, a1, b1, mask);
        wait_all_done("single request");
    endtask

    task automatic end_test(input string name, input int start_errors);
        test_count++;
        $display("test %-16s %s (%0d errors)", name,
                 (errors == start_errors) ? "passed" : "failed", errors - start_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic check_latency(input logic [3:0] code, input int expected);
        int   cycles;
        logic seen;
        send(code, 32'h3f800000, 32'hc0000000, 32'h00000000, 32'h80000000, 2'b11);
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            cycles++;
            seen = (valid_out === 1'b1);
            if (!seen && cycles > TIMEOUT) abort_run("no response for latency check");
        end
        if (cycles != expected) report_value("valid_out latency", cycles, expected);
        wait_all_done("latency check");
    endtask

    task automatic test_reset_latency();
        int start_errors;
        start_errors = errors;
        if (valid_out !== 1'b0) report_value("valid_out", valid_out, 1'b0);
        if (ready_in !== 1'b1) report_value("ready_in", ready_in, 1'b1);
        check_latency(OP_SGNJ, LAT_SIGN);
        check_latency(OP_FEQ, LAT_CMP);
        end_test("reset_latency", start_errors);
    endtask

    task automatic test_sign_inject();
        int start_errors;
        start_errors = errors;
        // the last pass uses a code that no operation owns
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < 6; n++) begin
                run_one((k == 3) ? 4'd13 : 4'(k), $urandom, $urandom, $urandom, $urandom, 2'b11);
            end
        end
        end_test("sign_inject", start_errors);
    endtask

    task automatic test_compare();
        int start_errors;
        start_errors = errors;
        for (int code = OP_FEQ; code <= OP_FLE; code++) begin
            for (int i = 0; i < 12; i++) begin
                for (int j = 0; j < 12; j++) begin
                    run_one(4'(code), special_value(i), special_value(j),
                            special_value(j), special_value(i), 2'b11);
                end
            end
        end
        // lane 1 carries a signaling NaN but only lane 0 is active
        run_one(OP_FEQ, 32'h3f800000, 32'h3f800000, 32'h7f800001, 32'h3f800000, 2'b01);
        if (last_rsp.fflags.nv !== 1'b0) report_value("rsp.fflags.nv", last_rsp.fflags.nv, 1'b0);
        run_one(OP_FLT, 32'h3f800000, 32'h40000000, 32'h7fc00000, 32'h3f800000, 2'b10);
        if (last_rsp.fflags.nv !== 1'b1) report_value("rsp.fflags.nv", last_rsp.fflags.nv, 1'b1);
        end_test("compare", start_errors);
    endtask

    task automatic test_minmax_class();
        int start_errors;
        start_errors = errors;
        for (int code = OP_FMIN; code <= OP_FMAX; code++) begin
            for (int i = 0; i < 12; i++) begin
                for (int j = 0; j < 12; j++) begin
                    run_one(4'(code), special_value(i), special_value(j),
                            special_value(j), special_value(i), 2'b11);
                end
            end
        end
        run_one(OP_FMIN, 32'h7fc00000, 32'h7f800001, 32'h80000000, 32'h00000000, 2'b11);
        if (last_rsp.result[0] !== QNAN_CANON) begin
            report_value("rsp.result[0]", last_rsp.result[0], QNAN_CANON);
        end
        for (int i = 0; i < 10; i += 2) begin
            run_one(OP_FCLASS, special_value(i), 32'h0, special_value(i + 1), 32'h0, 2'b11);
            if (last_rsp.has_fflags !== 1'b0) begin
                report_value("rsp.has_fflags", last_rsp.has_fflags, 1'b0);
            end
        end
        end_test("minmax_class", start_errors);
    endtask

    task test_backpressure();
        int start_errors;
        int guard;
        start_errors = errors;
        issue_done   = 1'b0;
        guard        = 0;
        fork
            begin
                for (int n = 0; n < 40; n++) begin
                    send(4'($urandom % 9), random_operand(), random_operand(),
                         random_operand(), random_operand(), 2'($urandom % 3 + 1));
                end
                issue_done = 1'b1;
            end
            begin
                while (!issue_done && guard < 40 * TIMEOUT) begin
                    @(negedge clk);
                    ready_out = ($urandom % 2) == 1;
                    guard++;
                end
            end
        join
        ready_out = 1'b1;
        wait_all_done("back-pressure burst");
        if (rx_count != issued_count) report_value("response count", rx_count, issued_count);
        if (sign_order.size() + cmp_order.size() != 0) begin
            report_fail("requests left without a response");
        end
        end_test("backpressure", start_errors);
    endtask

    initial begin
        void'($urandom(32'hd947d48d));
        errors       = 0;
        issued_count = 0;
        rx_count     = 0;
        next_tag     = 0;
        test_count   = 0;
        held         = 1'b0;
        for (int i = 0; i < (1 << TAG_W); i++) begin
            pending[i] = 1'b0;
        end
        valid_in  = 1'b0;
        req       = '0;
        ready_out = 1'b1;
        reset     = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        test_reset_latency();
        test_sign_inject();
        test_compare();
        test_minmax_class();
        test_backpressure();

        $display("summary: %0d tests, %0d requests, %0d responses, %0d errors",
                 test_count, issued_count, rx_count, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/fpu_ncp_pkg.sv
source/fpu_dispatch.sv
source/fpu_pipe_reg.sv
source/fpu_sign_unit.sv
source/fpu_cmp_unit.sv
source/fpu_rsp_arb.sv
source/fpu_ncp.sv
sim/tb_fpu_ncp.sv
